/* sim/upsizer_input.txt */
// Columns: data (64-bit hex), destination, user, last
// Packets are full, short and single-beat, the user tag changes on every beat
1000000000000001 0001 a100 0
2000000000000002 0001 a101 0
3000000000000003 0001 a102 0
4000000000000004 0001 a103 1
5000000000000005 0002 b200 0
6000000000000006 0002 b201 0
7000000000000007 0002 b202 1
8000000000000008 0003 c300 1
9000000000000009 0004 d400 1
a00000000000000a 0005 e500 0
b00000000000000b 0005 e501 0
c00000000000000c 0005 e502 0
d00000000000000d 0005 e503 0
e00000000000000e 0005 e504 1
f00000000000000f 0006 f600 0
0123456789abcdef 0006 f601 1
fedcba9876543210 0007 1700 1
00000000ffffffff 0008 2800 0
ffffffff00000000 0008 2801 0
5a5a5a5a5a5a5a5a 0008 2802 0
a5a5a5a5a5a5a5a5 0008 2803 1
0f0f0f0f0f0f0f0f 0009 3900 0
f0f0f0f0f0f0f0f0 0009 3901 0
0000000000000000 0009 3902 1

/* all.f */
common/axis_pkg.sv
common/upsizer_pkg.sv
src/axis_skid_buffer.sv
upsizer/upsizer.sv
src/upsizer_top.sv
sim/upsizer_tb.sv

/* sim/upsizer_tb.sv */
// Runs with the default 64 to 128 bit widths and reads sim/upsizer_input.txt from the project root
`timescale 1ns/1ps

module upsizer_tb;

    localparam int IN_W       = upsizer_pkg::DEFAULT_IN_WIDTH;
    localparam int OUT_W      = upsizer_pkg::DEFAULT_OUT_WIDTH;
    localparam int RATIO      = OUT_W / IN_W;
    localparam int MAX_BEATS  = 64;
    // The first packets run with no gaps and no stall, so they must end on a last beat
    localparam int FAST_BEATS = 8;

    logic                 clk;
    logic                 arst_n;
    logic [IN_W-1:0]      in_data;
    axis_pkg::dest_t      in_dest;
    axis_pkg::user_t      in_user;
    logic                 in_last;
    logic                 in_valid;
    logic                 in_ready;
    logic [OUT_W-1:0]     out_data;
    axis_pkg::keep_t      out_keep;
    axis_pkg::dest_t      out_dest;
    axis_pkg::user_t      out_user;
    logic                 out_last;
    logic                 out_valid;
    logic                 out_ready;

    // Each narrow beat takes four file words in the order data, destination, user and last
    logic [63:0]          beat_mem [0:4*MAX_BEATS-1];
    logic [IN_W-1:0]      beat_data [MAX_BEATS];
    axis_pkg::dest_t      beat_dest [MAX_BEATS];
    axis_pkg::user_t      beat_user [MAX_BEATS];
    logic                 beat_last [MAX_BEATS];
    logic                 beat_done [MAX_BEATS];
    int                   num_beats = 0;
    int                   fast_wide;

    // Expected wide beats in output order
    logic [OUT_W-1:0]     exp_data [$];
    axis_pkg::keep_t      exp_keep [$];
    axis_pkg::dest_t      exp_dest [$];
    axis_pkg::user_t      exp_user [$];
    logic                 exp_last [$];
    int                   exp_total;

    // Monitor state
    int                   cycle = 0;
    int                   in_count = 0;
    int                   out_count = 0;
    int                   lat_q [$];
    logic                 hold_pending = 1'b0;
    logic [OUT_W-1:0]     held_data;
    axis_pkg::keep_t      held_keep;
    axis_pkg::dest_t      held_dest;
    axis_pkg::user_t      held_user;
    logic                 held_last;
    logic [31:0]          lfsr_state = 32'he7cdeb08;

    upsizer_top #(
        .IN_WIDTH (IN_W),
        .OUT_WIDTH(OUT_W)
    ) dut0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_data  (in_data),
        .in_dest  (in_dest),
        .in_user  (in_user),
        .in_last  (in_last),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_data (out_data),
        .out_keep (out_keep),
        .out_dest (out_dest),
        .out_user (out_user),
        .out_last (out_last),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    always #5 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    task automatic check_value(input string name, input logic [OUT_W-1:0] expected,
                               input logic [OUT_W-1:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic load_beats();
        int count;
        count = 0;
        $readmemh("sim/upsizer_input.txt", beat_mem);
        while (count < MAX_BEATS && beat_mem[4*count] !== 'x) begin
            beat_data[count] = beat_mem[4*count][IN_W-1:0];
            beat_dest[count] = beat_mem[4*count+1][15:0];
            beat_user[count] = beat_mem[4*count+2][15:0];
            beat_last[count] = beat_mem[4*count+3][0];
            count++;
        end
        if (count < FAST_BEATS) begin
            $display("Input file holds too few beats to run the tests");
            $display("Done: errors found");
            $fatal(1, "Bad input file");
        end
        num_beats = count;
    endtask

    // Lane zero fills first and a wide beat closes on the final lane or on last
    // Lanes left empty by an early close stay zero
    task automatic build_expected();
        int lane;
        logic [OUT_W-1:0] acc_data;
        axis_pkg::keep_t  acc_keep;
        axis_pkg::dest_t  acc_dest;
        axis_pkg::user_t  acc_user;
        lane = 0;
        fast_wide = 0;
        for (int i = 0; i < num_beats; i++) begin
            if (lane == 0) begin
                acc_data = '0;
                acc_keep = '0;
                acc_dest = beat_dest[i];
                acc_user = beat_user[i];
            end
            acc_data[lane*IN_W +: IN_W] = beat_data[i];
            acc_keep[lane] = 1'b1;
            beat_done[i] = beat_last[i] || (lane == RATIO - 1);
            if (beat_done[i]) begin
                exp_data.push_back(acc_data);
                exp_keep.push_back(acc_keep);
                exp_dest.push_back(acc_dest);
                exp_user.push_back(acc_user);
                exp_last.push_back(beat_last[i]);
                if (i < FAST_BEATS) begin
                    fast_wide++;
                end
                lane = 0;
            end else begin
                lane++;
            end
        end
        exp_total = exp_data.size();
    endtask

    // Presents beats first up to stop, holding each one until it transfers
    task automatic drive_beats(input int first, input int stop, input logic random_mode);
        int   pos;
        logic pending;
        logic r0;
        logic r1;
        pos = first;
        pending = 1'b0;
        while (pos < stop) begin
            @(posedge clk);
            r0 = 1'b1;
            r1 = 1'b1;
            if (random_mode) begin
                r0 = next_random_bit();
                r1 = next_random_bit();
            end
            out_ready <= r0 | r1;
            if (pending && in_ready) begin
                pending = 1'b0;
                pos++;
            end
            if (!pending) begin
                r0 = 1'b1;
                r1 = 1'b1;
                if (random_mode && pos < stop) begin
                    r0 = next_random_bit();
                    r1 = next_random_bit();
                end
                if (pos < stop && (r0 | r1)) begin
                    in_data  <= beat_data[pos];
                    in_dest  <= beat_dest[pos];
                    in_user  <= beat_user[pos];
                    in_last  <= beat_last[pos];
                    in_valid <= 1'b1;
                    pending = 1'b1;
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    endtask

    // The output count is read at the falling edge once the monitor has settled it
    task automatic drain_outputs(input int target, input logic random_mode);
        logic r0;
        logic r1;
        while (out_count < target) begin
            @(posedge clk);
            r0 = 1'b1;
            r1 = 1'b1;
            if (random_mode) begin
                r0 = next_random_bit();
                r1 = next_random_bit();
            end
            out_ready <= r0 | r1;
            @(negedge clk);
        end
    endtask

    // Samples at rising edges, before the DUT registers update
    always @(posedge clk) begin
        // A stalled wide beat must stay put until it transfers
        if (hold_pending) begin
            check_value("out_valid", 1, out_valid);
            check_value("out_data", held_data, out_data);
            check_value("out_keep", held_keep, out_keep);
            check_value("out_dest", held_dest, out_dest);
            check_value("out_user", held_user, out_user);
            check_value("out_last", held_last, out_last);
        end
        hold_pending = out_valid && !out_ready;
        held_data = out_data;
        held_keep = out_keep;
        held_dest = out_dest;
        held_user = out_user;
        held_last = out_last;
        if (in_valid && in_ready) begin
            if (in_count < FAST_BEATS && beat_done[in_count]) begin
                lat_q.push_back(cycle);
            end
            in_count++;
        end
        if (out_valid && out_ready) begin
            if (exp_data.size() == 0) begin
                $display("A wide beat arrived at %0t ns after all expected beats", $time);
                $display("Done: errors found");
                $fatal(1, "Extra output beat");
            end else begin
                check_value("out_data", exp_data.pop_front(), out_data);
                check_value("out_keep", exp_keep.pop_front(), out_keep);
                check_value("out_dest", exp_dest.pop_front(), out_dest);
                check_value("out_user", exp_user.pop_front(), out_user);
                check_value("out_last", exp_last.pop_front(), out_last);
                // Unstalled path is two cycles from the completing input transfer
                if (out_count < fast_wide) begin
                    check_value("latency", 2, cycle - lat_q.pop_front());
                end
                out_count++;
            end
        end
        cycle++;
    end

    initial begin
        wait (num_beats != 0);
        repeat (num_beats * 40) @(posedge clk);
        $display("Run timed out after %0d cycles with the packer in state %s",
                 num_beats * 40, dut0.u_pack.state.name());
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        in_data   = '0;
        in_dest   = '0;
        in_user   = '0;
        in_last   = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        load_beats();
        build_expected();
        // Nothing may look valid or ready while reset is held
        repeat (4) begin
            @(posedge clk);
            check_value("in_ready", 0, in_ready);
            check_value("out_valid", 0, out_valid);
        end
        arst_n <= 1'b1;
        @(posedge clk);
        check_value("in_ready", 0, in_ready);
        check_value("out_valid", 0, out_valid);
        @(posedge clk);
        check_value("in_ready", 1, in_ready);
        drive_beats(0, FAST_BEATS, 1'b0);
        drain_outputs(fast_wide, 1'b0);
        drive_beats(FAST_BEATS, num_beats, 1'b1);
        drain_outputs(exp_total, 1'b1);
        // Extra idle cycles would expose a duplicated beat
        repeat (5) begin
            @(posedge clk);
            out_ready <= 1'b1;
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

/* src/upsizer_top.sv */
// Latency from input transfer to out_valid is two cycles when the output is not stalled
`timescale 1ns/1ps

module upsizer_top #(
    parameter int IN_WIDTH  = upsizer_pkg::DEFAULT_IN_WIDTH,
    parameter int OUT_WIDTH = upsizer_pkg::DEFAULT_OUT_WIDTH
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [IN_WIDTH-1:0]  in_data,
    input  axis_pkg::dest_t      in_dest,
    input  axis_pkg::user_t      in_user,
    input  logic                 in_last,
    input  logic                 in_valid,
    output logic                 in_ready,
    output logic [OUT_WIDTH-1:0] out_data,
    output axis_pkg::keep_t      out_keep,
    output axis_pkg::dest_t      out_dest,
    output axis_pkg::user_t      out_user,
    output logic                 out_last,
    output logic                 out_valid,
    input  logic                 out_ready
);

    // Registered narrow stream between the skid buffer and the packer
    logic [IN_WIDTH-1:0] mid_data;
    axis_pkg::dest_t     mid_dest;
    axis_pkg::user_t     mid_user;
    logic                mid_last;
    logic                mid_valid;
    logic                mid_ready;

    // Skid buffer isolates the source from the packer's ready path
    axis_skid_buffer #(
        .DATA_WIDTH(IN_WIDTH)
    ) u_skid (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_data  (in_data),
        .in_dest  (in_dest),
        .in_user  (in_user),
        .in_last  (in_last),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .mid_data (mid_data),
        .mid_dest (mid_dest),
        .mid_user (mid_user),
        .mid_last (mid_last),
        .mid_valid(mid_valid),
        .mid_ready(mid_ready)
    );

    upsizer #(
        .IN_WIDTH (IN_WIDTH),
        .OUT_WIDTH(OUT_WIDTH)
    ) u_pack (
        .clk      (clk),
        .arst_n   (arst_n),
        .mid_data (mid_data),
        .mid_dest (mid_dest),
        .mid_user (mid_user),
        .mid_last (mid_last),
        .mid_valid(mid_valid),
        .mid_ready(mid_ready),
        .out_data (out_data),
        .out_keep (out_keep),
        .out_dest (out_dest),
        .out_user (out_user),
        .out_last (out_last),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

/* upsizer/upsizer.sv */
// OUT_WIDTH must be an exact multiple of IN_WIDTH with a ratio from 2 up to axis_pkg::MAX_LANES
`timescale 1ns/1ps

module upsizer #(
    parameter int IN_WIDTH  = 64,
    parameter int OUT_WIDTH = 128
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [IN_WIDTH-1:0]  mid_data,
    input  axis_pkg::dest_t      mid_dest,
    input  axis_pkg::user_t      mid_user,
    input  logic                 mid_last,
    input  logic                 mid_valid,
    output logic                 mid_ready,
    output logic [OUT_WIDTH-1:0] out_data,
    output axis_pkg::keep_t      out_keep,
    output axis_pkg::dest_t      out_dest,
    output axis_pkg::user_t      out_user,
    output logic                 out_last,
    output logic                 out_valid,
    input  logic                 out_ready
);

    localparam int RATIO  = OUT_WIDTH / IN_WIDTH;
    localparam int LANE_W = $clog2(RATIO);

    upsizer_pkg::pack_state_t state;
    upsizer_pkg::pack_state_t state_n;

    // Lane that the next narrow beat lands in
    logic [LANE_W-1:0] lane_cnt;
    logic [LANE_W-1:0] lane_cnt_n;

    // Set when the fill register holds a finished wide beat waiting for the output register
    logic fill_done;
    logic fill_done_n;

    // Fill register collecting the next wide beat
    logic [OUT_WIDTH-1:0] fill_data;
    axis_pkg::keep_t      fill_keep;
    axis_pkg::dest_t      fill_dest;
    axis_pkg::user_t      fill_user;
    logic                 fill_last;

    // Fill register contents with the incoming narrow beat written into its lane
    logic [OUT_WIDTH-1:0] merge_data;
    axis_pkg::keep_t      merge_keep;
    axis_pkg::dest_t      merge_dest;
    axis_pkg::user_t      merge_user;

    logic mid_fire;
    logic completing;
    logic out_free;
    logic take_fill;
    logic take_merge;
    logic park;
    logic acc;
    logic out_full_n;

    // New beats are refused only when a finished beat already sits behind the output
    assign mid_ready  = !fill_done;
    assign mid_fire   = mid_valid && mid_ready;

    // The final lane or a last flag closes the wide beat
    assign completing = mid_fire && (mid_last || lane_cnt == LANE_W'(RATIO - 1));

    // Lane zero starts a new wide beat, so older lanes are cleared rather than kept
    always_comb begin
        merge_data = '0;
        merge_keep = '0;
        for (int i = 0; i < RATIO; i++) begin
            if (i == int'(lane_cnt)) begin
                merge_data[i*IN_WIDTH +: IN_WIDTH] = mid_data;
            end else if (lane_cnt != '0) begin
                merge_data[i*IN_WIDTH +: IN_WIDTH] = fill_data[i*IN_WIDTH +: IN_WIDTH];
            end
            merge_keep[i] = (i <= int'(lane_cnt));
        end
    end

    // Tags always come from the first narrow beat of the wide beat
    assign merge_dest = (lane_cnt == '0) ? mid_dest : fill_dest;
    assign merge_user = (lane_cnt == '0) ? mid_user : fill_user;

    // Output register is free when empty or when its beat leaves at this edge
    always_comb begin
        case (state)
            upsizer_pkg::FILLING: out_free = 1'b1;
            default:              out_free = out_ready;
        endcase
    end

    assign take_fill  = out_free && fill_done;
    assign take_merge = out_free && !fill_done && completing;
    assign park       = !out_free && completing;
    assign acc        = mid_fire && !completing;

    // Counter restarts whenever a wide beat is closed, parked or not
    always_comb begin
        lane_cnt_n  = lane_cnt;
        fill_done_n = fill_done;
        if (take_fill) begin
            fill_done_n = 1'b0;
        end
        if (take_merge || park) begin
            lane_cnt_n  = '0;
            fill_done_n = park;
        end else if (acc) begin
            lane_cnt_n = lane_cnt + 1'b1;
        end
    end

    // The state records whether the output register is occupied and whether
    // the fill register has started on the next wide beat
    assign out_full_n = take_fill || take_merge || (state != upsizer_pkg::FILLING && !out_ready);

    always_comb begin
        if (!out_full_n) begin
            state_n = upsizer_pkg::FILLING;
        end else if (lane_cnt_n != '0 || fill_done_n) begin
            state_n = upsizer_pkg::HOLD_FILL;
        end else begin
            state_n = upsizer_pkg::HOLDING;
        end
    end

    assign out_valid = (state != upsizer_pkg::FILLING);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= upsizer_pkg::FILLING;
            lane_cnt  <= '0;
            fill_done <= 1'b0;
        end else begin
            state     <= state_n;
            lane_cnt  <= lane_cnt_n;
            fill_done <= fill_done_n;
        end
    end

    // Payload registers follow the control decisions above
    always_ff @(posedge clk) begin
        if (acc || park) begin
            fill_data <= merge_data;
            fill_keep <= merge_keep;
            fill_dest <= merge_dest;
            fill_user <= merge_user;
            fill_last <= mid_last;
        end
        if (take_fill) begin
            out_data <= fill_data;
            out_keep <= fill_keep;
            out_dest <= fill_dest;
            out_user <= fill_user;
            out_last <= fill_last;
        end else if (take_merge) begin
            out_data <= merge_data;
            out_keep <= merge_keep;
            out_dest <= merge_dest;
            out_user <= merge_user;
            out_last <= mid_last;
        end
    end

endmodule

/* src/axis_skid_buffer.sv */
// Holds at most two beats and in_ready is registered, so it lags the stall by one cycle
`timescale 1ns/1ps

module axis_skid_buffer #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [DATA_WIDTH-1:0] in_data,
    input  axis_pkg::dest_t       in_dest,
    input  axis_pkg::user_t       in_user,
    input  logic                  in_last,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic [DATA_WIDTH-1:0] mid_data,
    output axis_pkg::dest_t       mid_dest,
    output axis_pkg::user_t       mid_user,
    output logic                  mid_last,
    output logic                  mid_valid,
    input  logic                  mid_ready
);

    // Skid entry that catches the beat accepted while the main entry stalls
    logic [DATA_WIDTH-1:0] skid_data;
    axis_pkg::dest_t       skid_dest;
    axis_pkg::user_t       skid_user;
    logic                  skid_last;
    logic                  skid_valid;

    logic in_fire;
    logic main_free;
    logic skid_load;
    logic main_valid_n;
    logic skid_valid_n;

    assign in_fire   = in_valid && in_ready;

    // The main entry can take a new beat when it is empty or is leaving this cycle
    assign main_free = !mid_valid || mid_ready;

    // Incoming beat goes to the skid entry when the main entry is busy
    // or when the skid entry is moving into the main entry at the same edge
    assign skid_load = in_fire && (!main_free || skid_valid);

    // Occupancy after the coming edge
    // The skid entry is only ever valid while the main entry is valid
    always_comb begin
        main_valid_n = mid_valid;
        skid_valid_n = skid_valid;
        if (main_free) begin
            main_valid_n = skid_valid || in_fire;
            skid_valid_n = skid_valid && in_fire;
        end else if (in_fire) begin
            skid_valid_n = 1'b1;
        end
    end

    // Ready is computed from the next occupancy so it is exact one edge ahead
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mid_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            mid_valid  <= main_valid_n;
            skid_valid <= skid_valid_n;
            in_ready   <= !(main_valid_n && skid_valid_n);
        end
    end

    // Older beat in the skid entry always drains first to keep order
    always_ff @(posedge clk) begin
        if (main_free) begin
            if (skid_valid) begin
                mid_data <= skid_data;
                mid_dest <= skid_dest;
                mid_user <= skid_user;
                mid_last <= skid_last;
            end else if (in_fire) begin
                mid_data <= in_data;
                mid_dest <= in_dest;
                mid_user <= in_user;
                mid_last <= in_last;
            end
        end
        if (skid_load) begin
            skid_data <= in_data;
            skid_dest <= in_dest;
            skid_user <= in_user;
            skid_last <= in_last;
        end
    end

endmodule

/* common/upsizer_pkg.sv */
// Default widths assume the wide width is an exact multiple of the narrow width
package upsizer_pkg;

    // Narrow input data width used when the top level is not overridden
    localparam int DEFAULT_IN_WIDTH = 64;

    // Wide output data width used when the top level is not overridden
    localparam int DEFAULT_OUT_WIDTH = 128;

    // Packing state machine of the upsizer
    // FILLING means the output register is empty and lanes are being collected
    // HOLDING means a wide beat waits for output ready and no new lane is collected yet
    // HOLD_FILL means a wide beat waits while the next one is partly or fully collected
    typedef enum logic [1:0] {
        FILLING   = 2'd0,
        HOLDING   = 2'd1,
        HOLD_FILL = 2'd2
    } pack_state_t;

endpackage

/* common/axis_pkg.sv */
// Stream tag widths are fixed at 16 bits and the lane keep vector covers at most MAX_LANES lanes
package axis_pkg;

    // Destination tag width, the same on narrow and wide streams
    localparam int DEST_WIDTH = 16;

    // User tag width, carried unchanged from the first narrow beat
    localparam int USER_WIDTH = 16;

    // Largest width ratio any upsizer instance may use
    // The keep vector is sized by it so that every stream port shares one keep type
    localparam int MAX_LANES = 8;

    // Destination tag of a stream beat
    typedef logic [DEST_WIDTH-1:0] dest_t;

    // User tag of a stream beat
    typedef logic [USER_WIDTH-1:0] user_t;

    // One bit per narrow lane of a wide beat
    // A set bit marks a lane that holds a real narrow beat
    // Only the low ratio bits are ever set, the rest stay zero
    typedef logic [MAX_LANES-1:0] keep_t;

endpackage
